// ==== verilog/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

  localparam int XLEN = 64;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [11:0]     csr_addr_t;
  typedef logic [3:0]      ecode_t;

  typedef enum logic [3:0] {
    OP_NONE,
    OP_CSRRW,
    OP_CSRRS,
    OP_CSRRC,
    OP_CSRRWI,
    OP_CSRRSI,
    OP_CSRRCI,
    OP_MRET,
    OP_WFI
  } csr_op_e;

  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_e;

  // Highest cause first, so bit 0 is instr_misaligned
  typedef struct packed {
    logic ecall;
    logic store_access_fault;
    logic store_misaligned;
    logic load_access_fault;
    logic load_misaligned;
    logic breakpoint;
    logic illegal_instr;
    logic instr_misaligned;
  } exc_flags_t;

  typedef struct packed {
    csr_op_e    op;
    csr_addr_t  addr;
    xlen_t      wdata;
    xlen_t      pc;
    xlen_t      npc;
    xlen_t      vaddr;
    exc_flags_t exc;
  } csr_req_t;

  typedef struct packed {
    logic  instret;
    logic  trap;
    logic  interrupt;
    logic  eret;
    xlen_t rdata;
    xlen_t npc;
    priv_e priv_n;
  } commit_t;

  localparam csr_addr_t CSR_MSTATUS   = 12'h300;
  localparam csr_addr_t CSR_MISA      = 12'h301;
  localparam csr_addr_t CSR_MIE       = 12'h304;
  localparam csr_addr_t CSR_MTVEC     = 12'h305;
  localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
  localparam csr_addr_t CSR_MEPC      = 12'h341;
  localparam csr_addr_t CSR_MCAUSE    = 12'h342;
  localparam csr_addr_t CSR_MTVAL     = 12'h343;
  localparam csr_addr_t CSR_MIP       = 12'h344;
  localparam csr_addr_t CSR_MCYCLE    = 12'hB00;
  localparam csr_addr_t CSR_MINSTRET  = 12'hB02;
  localparam csr_addr_t CSR_CYCLE     = 12'hC00;
  localparam csr_addr_t CSR_INSTRET   = 12'hC02;
  localparam csr_addr_t CSR_MVENDORID = 12'hF11;
  localparam csr_addr_t CSR_MARCHID   = 12'hF12;
  localparam csr_addr_t CSR_MIMPID    = 12'hF13;
  localparam csr_addr_t CSR_MHARTID   = 12'hF14;

  // RV64 with I, M and U
  localparam xlen_t MISA_VALUE    = {2'b10, 36'b0, 26'h0101100};
  localparam xlen_t MARCHID_VALUE = 64'd5;
  localparam xlen_t MIMPID_VALUE  = 64'd1;

  localparam ecode_t CAUSE_INSTR_MISALIGNED = 4'd0;
  localparam ecode_t CAUSE_ILLEGAL          = 4'd2;
  localparam ecode_t CAUSE_BREAKPOINT       = 4'd3;
  localparam ecode_t CAUSE_LOAD_MISALIGNED  = 4'd4;
  localparam ecode_t CAUSE_LOAD_FAULT       = 4'd5;
  localparam ecode_t CAUSE_STORE_MISALIGNED = 4'd6;
  localparam ecode_t CAUSE_STORE_FAULT      = 4'd7;
  localparam ecode_t CAUSE_ECALL_U          = 4'd8;
  localparam ecode_t CAUSE_ECALL_M          = 4'd11;

  // Interrupt codes double as mie/mip bit positions
  localparam ecode_t IRQ_MSI = 4'd3;
  localparam ecode_t IRQ_MTI = 4'd7;
  localparam ecode_t IRQ_MEI = 4'd11;

  localparam int MSTATUS_MIE  = 3;
  localparam int MSTATUS_MPIE = 7;
  localparam int MSTATUS_MPP  = 11;

endpackage

`default_nettype wire

// ==== verilog/csr_operand.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_operand
  (input csr_pkg::csr_req_t  req_i
   , input csr_pkg::priv_e   priv_i
   , input csr_pkg::xlen_t   cur_value_i
   , output csr_pkg::xlen_t  wr_value_o
   , output logic            access_ok_o
   , output logic            illegal_o
   );

  import csr_pkg::*;

  logic  is_csr;
  logic  is_imm;
  xlen_t src;
  logic  addr_known;
  logic  priv_ok;
  logic  ro_write;

  assign is_csr = req_i.op inside {OP_CSRRW, OP_CSRRS, OP_CSRRC,
                                   OP_CSRRWI, OP_CSRRSI, OP_CSRRCI};
  assign is_imm = req_i.op inside {OP_CSRRWI, OP_CSRRSI, OP_CSRRCI};

  // Immediate forms only carry a 5-bit zimm
  assign src = is_imm ? xlen_t'(req_i.wdata[4:0]) : req_i.wdata;

  always_comb
    begin
      case (req_i.op)
        OP_CSRRW, OP_CSRRWI: wr_value_o = src;
        OP_CSRRS, OP_CSRRSI: wr_value_o = cur_value_i | src;
        OP_CSRRC, OP_CSRRCI: wr_value_o = cur_value_i & ~src;
        default:             wr_value_o = cur_value_i;
      endcase
    end

  always_comb
    begin
      case (req_i.addr)
        CSR_MSTATUS,
        CSR_MISA,
        CSR_MIE,
        CSR_MTVEC,
        CSR_MSCRATCH,
        CSR_MEPC,
        CSR_MCAUSE,
        CSR_MTVAL,
        CSR_MIP,
        CSR_MCYCLE,
        CSR_MINSTRET,
        CSR_CYCLE,
        CSR_INSTRET,
        CSR_MVENDORID,
        CSR_MARCHID,
        CSR_MIMPID,
        CSR_MHARTID: addr_known = 1'b1;
        default:     addr_known = 1'b0;
      endcase
    end

  // Address bits 9:8 hold the lowest privilege allowed
  assign priv_ok  = priv_i >= req_i.addr[9:8];
  assign ro_write = (req_i.addr[11:10] == 2'b11) && (src != '0);

  assign access_ok_o = is_csr & addr_known & priv_ok & ~ro_write;
  assign illegal_o   = is_csr & (~addr_known | ~priv_ok | ro_write);

endmodule

`default_nettype wire

// ==== verilog/csr_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_regfile
  #(parameter csr_pkg::xlen_t HART_ID = 64'd0)
  (input logic                 clk_i
   , input logic               arst_n_i

   , input logic               req_valid_i
   , input csr_pkg::csr_req_t  req_i
   , input csr_pkg::xlen_t     wr_value_i
   , input logic               access_ok_i

   , input logic               take_trap_i
   , input logic               trap_irq_i
   , input csr_pkg::ecode_t    trap_cause_i
   , input csr_pkg::xlen_t     trap_tval_i
   , input csr_pkg::xlen_t     trap_pc_i
   , input logic               do_mret_i
   , input csr_pkg::priv_e     priv_i
   , input logic [2:0]         irq_lines_i

   , output csr_pkg::xlen_t    rd_value_o
   , output csr_pkg::xlen_t    mstatus_o
   , output csr_pkg::xlen_t    mie_o
   , output csr_pkg::xlen_t    mip_o
   , output csr_pkg::xlen_t    mtvec_o
   , output csr_pkg::xlen_t    mepc_o
   );

  import csr_pkg::*;

  localparam xlen_t MIE_MASK = (xlen_t'(1) << IRQ_MSI)
                             | (xlen_t'(1) << IRQ_MTI)
                             | (xlen_t'(1) << IRQ_MEI);

  logic  mst_mie;
  logic  mst_mpie;
  priv_e mst_mpp;

  xlen_t mie_q;
  xlen_t mtvec_q;
  xlen_t mscratch_q;
  xlen_t mepc_q;
  xlen_t mcause_q;
  xlen_t mtval_q;
  xlen_t mcycle_q;
  xlen_t minstret_q;

  logic  sw_write;
  logic  retire;

  // Set and clear with a zero source read only
  assign sw_write = req_valid_i & access_ok_i & ~take_trap_i
                  & ((req_i.op inside {OP_CSRRW, OP_CSRRWI}) | (req_i.wdata != '0));
  assign retire   = req_valid_i & ~take_trap_i;

  always_comb
    begin
      mstatus_o = '0;
      mstatus_o[MSTATUS_MIE] = mst_mie;
      mstatus_o[MSTATUS_MPIE] = mst_mpie;
      mstatus_o[MSTATUS_MPP +: 2] = mst_mpp;
    end

  // Pending bits follow the lines directly
  always_comb
    begin
      mip_o = '0;
      mip_o[IRQ_MSI] = irq_lines_i[0];
      mip_o[IRQ_MTI] = irq_lines_i[1];
      mip_o[IRQ_MEI] = irq_lines_i[2];
    end

  assign mie_o   = mie_q;
  assign mtvec_o = mtvec_q;
  assign mepc_o  = mepc_q;

  always_comb
    begin
      case (req_i.addr)
        CSR_MSTATUS:               rd_value_o = mstatus_o;
        CSR_MISA:                  rd_value_o = MISA_VALUE;
        CSR_MIE:                   rd_value_o = mie_q;
        CSR_MTVEC:                 rd_value_o = mtvec_q;
        CSR_MSCRATCH:              rd_value_o = mscratch_q;
        CSR_MEPC:                  rd_value_o = mepc_q;
        CSR_MCAUSE:                rd_value_o = mcause_q;
        CSR_MTVAL:                 rd_value_o = mtval_q;
        CSR_MIP:                   rd_value_o = mip_o;
        CSR_MCYCLE, CSR_CYCLE:     rd_value_o = mcycle_q;
        CSR_MINSTRET, CSR_INSTRET: rd_value_o = minstret_q;
        CSR_MARCHID:               rd_value_o = MARCHID_VALUE;
        CSR_MIMPID:                rd_value_o = MIMPID_VALUE;
        CSR_MHARTID:               rd_value_o = HART_ID;
        default:                   rd_value_o = '0;
      endcase
    end

  always_ff @(posedge clk_i or negedge arst_n_i)
    begin
      if (!arst_n_i)
        begin
          mst_mie    <= 1'b0;
          mst_mpie   <= 1'b0;
          mst_mpp    <= PRIV_U;
          mie_q      <= '0;
          mcycle_q   <= '0;
          minstret_q <= '0;
        end
      else
        begin
          if (take_trap_i)
            begin
              mst_mpie <= mst_mie;
              mst_mie  <= 1'b0;
              mst_mpp  <= priv_i;
            end
          else if (do_mret_i)
            begin
              mst_mie  <= mst_mpie;
              mst_mpie <= 1'b1;
              mst_mpp  <= PRIV_U;
            end
          else if (sw_write && (req_i.addr == CSR_MSTATUS))
            begin
              mst_mie  <= wr_value_i[MSTATUS_MIE];
              mst_mpie <= wr_value_i[MSTATUS_MPIE];
              // Only U and M exist
              mst_mpp  <= (wr_value_i[MSTATUS_MPP +: 2] == 2'b11) ? PRIV_M : PRIV_U;
            end

          if (sw_write && (req_i.addr == CSR_MIE))
            mie_q <= wr_value_i & MIE_MASK;

          if (sw_write && (req_i.addr == CSR_MCYCLE))
            mcycle_q <= wr_value_i;
          else
            mcycle_q <= mcycle_q + xlen_t'(1);

          if (sw_write && (req_i.addr == CSR_MINSTRET))
            minstret_q <= wr_value_i;
          else if (retire)
            minstret_q <= minstret_q + xlen_t'(1);
        end
    end

  always_ff @(posedge clk_i)
    begin
      if (take_trap_i)
        begin
          mepc_q   <= trap_pc_i;
          mcause_q <= {trap_irq_i, {(XLEN-5){1'b0}}, trap_cause_i};
          mtval_q  <= trap_tval_i;
        end
      else if (sw_write)
        begin
          case (req_i.addr)
            CSR_MTVEC:    mtvec_q    <= wr_value_i;
            CSR_MSCRATCH: mscratch_q <= wr_value_i;
            CSR_MEPC:     mepc_q     <= wr_value_i;
            CSR_MCAUSE:   mcause_q   <= wr_value_i;
            CSR_MTVAL:    mtval_q    <= wr_value_i;
            default:      ;
          endcase
        end
    end

  a_trap_mret_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(take_trap_i && do_mret_i));

endmodule

`default_nettype wire

// ==== verilog/trap_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module trap_ctrl
  #(parameter csr_pkg::xlen_t BOOT_PC = 64'd0)
  (input logic                 clk_i
   , input logic               arst_n_i

   , input logic               req_valid_i
   , input csr_pkg::csr_req_t  req_i
   , input logic               illegal_i
   , input csr_pkg::xlen_t     rd_value_i

   , input csr_pkg::xlen_t     mstatus_i
   , input csr_pkg::xlen_t     mie_i
   , input csr_pkg::xlen_t     mip_i
   , input csr_pkg::xlen_t     mtvec_i
   , input csr_pkg::xlen_t     mepc_i

   , output logic              take_trap_o
   , output logic              trap_irq_o
   , output csr_pkg::ecode_t   trap_cause_o
   , output csr_pkg::xlen_t    trap_tval_o
   , output csr_pkg::xlen_t    trap_pc_o
   , output logic              do_mret_o
   , output csr_pkg::priv_e    priv_o
   , output logic              irq_pending_o

   , output logic              commit_valid_o
   , output csr_pkg::commit_t  commit_o
   );

  import csr_pkg::*;

  priv_e      priv_q;
  xlen_t      apc_q;
  logic       commit_valid_q;
  commit_t    commit_q;

  logic       gie;
  logic       irq_mei;
  logic       irq_msi;
  logic       irq_mti;
  logic       irq_take;
  ecode_t     irq_cause;

  exc_flags_t exc;
  ecode_t     exc_cause;
  logic       exc_take;

  xlen_t      npc;
  priv_e      priv_n;

  // U mode is always open, M mode only with MIE
  assign gie     = (priv_q == PRIV_U) | mstatus_i[MSTATUS_MIE];
  assign irq_mei = mie_i[IRQ_MEI] & mip_i[IRQ_MEI];
  assign irq_msi = mie_i[IRQ_MSI] & mip_i[IRQ_MSI];
  assign irq_mti = mie_i[IRQ_MTI] & mip_i[IRQ_MTI];

  assign irq_pending_o = gie & (irq_mei | irq_msi | irq_mti);
  assign irq_take      = req_valid_i & irq_pending_o;
  assign irq_cause     = irq_mei ? IRQ_MEI : (irq_msi ? IRQ_MSI : IRQ_MTI);

  always_comb
    begin
      exc = req_i.exc;
      exc.illegal_instr = req_i.exc.illegal_instr | illegal_i
                        | ((req_i.op == OP_MRET) && (priv_q == PRIV_U));
    end

  // Lowest cause code wins
  always_comb
    begin
      if (exc.instr_misaligned)        exc_cause = CAUSE_INSTR_MISALIGNED;
      else if (exc.illegal_instr)      exc_cause = CAUSE_ILLEGAL;
      else if (exc.breakpoint)         exc_cause = CAUSE_BREAKPOINT;
      else if (exc.load_misaligned)    exc_cause = CAUSE_LOAD_MISALIGNED;
      else if (exc.load_access_fault)  exc_cause = CAUSE_LOAD_FAULT;
      else if (exc.store_misaligned)   exc_cause = CAUSE_STORE_MISALIGNED;
      else if (exc.store_access_fault) exc_cause = CAUSE_STORE_FAULT;
      else
        exc_cause = (priv_q == PRIV_U) ? CAUSE_ECALL_U : CAUSE_ECALL_M;
    end

  assign exc_take = req_valid_i & (|exc);

  assign take_trap_o  = irq_take | exc_take;
  assign trap_irq_o   = irq_take;
  assign trap_cause_o = irq_take ? irq_cause : exc_cause;
  assign trap_tval_o  = (!irq_take && (exc_cause inside {CAUSE_INSTR_MISALIGNED,
                                                         CAUSE_LOAD_MISALIGNED,
                                                         CAUSE_LOAD_FAULT,
                                                         CAUSE_STORE_MISALIGNED,
                                                         CAUSE_STORE_FAULT}))
                        ? req_i.vaddr : '0;
  // Interrupts resume at the architectural PC
  assign trap_pc_o    = irq_take ? apc_q : req_i.pc;
  assign do_mret_o    = req_valid_i & (req_i.op == OP_MRET) & ~take_trap_o;

  assign npc    = take_trap_o ? {mtvec_i[XLEN-1:2], 2'b00}
                : do_mret_o   ? mepc_i
                :               req_i.npc;
  assign priv_n = take_trap_o ? PRIV_M
                : do_mret_o   ? priv_e'(mstatus_i[MSTATUS_MPP +: 2])
                :               priv_q;

  always_ff @(posedge clk_i or negedge arst_n_i)
    begin
      if (!arst_n_i)
        begin
          priv_q         <= PRIV_M;
          apc_q          <= BOOT_PC;
          commit_valid_q <= 1'b0;
        end
      else
        begin
          commit_valid_q <= req_valid_i;
          if (req_valid_i)
            begin
              priv_q <= priv_n;
              apc_q  <= npc;
            end
        end
    end

  always_ff @(posedge clk_i)
    begin
      if (req_valid_i)
        begin
          commit_q.instret   <= ~take_trap_o;
          commit_q.trap      <= take_trap_o;
          commit_q.interrupt <= irq_take;
          commit_q.eret      <= do_mret_o;
          commit_q.rdata     <= take_trap_o ? '0 : rd_value_i;
          commit_q.npc       <= npc;
          commit_q.priv_n    <= priv_n;
        end
    end

  assign priv_o         = priv_q;
  assign commit_valid_o = commit_valid_q;
  assign commit_o       = commit_q;

  // The handler starts with M-mode interrupts closed
  a_trap_closes_mie: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $past(take_trap_o) |-> !mstatus_i[MSTATUS_MIE]);

endmodule

`default_nettype wire

// ==== verilog/csr_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_unit
  #(parameter csr_pkg::xlen_t BOOT_PC = 64'h0000_0000_8000_0000
    , parameter csr_pkg::xlen_t HART_ID = 64'd0
    )
  (input logic                 clk_i
   , input logic               arst_n_i

   , input logic               req_valid_i
   , input csr_pkg::csr_req_t  req_i

   , input logic               timer_irq_i
   , input logic               soft_irq_i
   , input logic               ext_irq_i

   , output logic              commit_valid_o
   , output csr_pkg::commit_t  commit_o
   , output logic              irq_pending_o
   );

  import csr_pkg::*;

  priv_e  priv;
  xlen_t  wr_value;
  xlen_t  rd_value;
  logic   access_ok;
  logic   illegal;

  xlen_t  mstatus;
  xlen_t  mie;
  xlen_t  mip;
  xlen_t  mtvec;
  xlen_t  mepc;

  logic   take_trap;
  logic   trap_irq;
  ecode_t trap_cause;
  xlen_t  trap_tval;
  xlen_t  trap_pc;
  logic   do_mret;

  csr_operand u_operand
    (.req_i        (req_i)
     , .priv_i      (priv)
     , .cur_value_i (rd_value)
     , .wr_value_o  (wr_value)
     , .access_ok_o (access_ok)
     , .illegal_o   (illegal)
     );

  csr_regfile #(.HART_ID(HART_ID)) u_regfile
    (.clk_i          (clk_i)
     , .arst_n_i     (arst_n_i)
     , .req_valid_i  (req_valid_i)
     , .req_i        (req_i)
     , .wr_value_i   (wr_value)
     , .access_ok_i  (access_ok)
     , .take_trap_i  (take_trap)
     , .trap_irq_i   (trap_irq)
     , .trap_cause_i (trap_cause)
     , .trap_tval_i  (trap_tval)
     , .trap_pc_i    (trap_pc)
     , .do_mret_i    (do_mret)
     , .priv_i       (priv)
     , .irq_lines_i  ({ext_irq_i, timer_irq_i, soft_irq_i})
     , .rd_value_o   (rd_value)
     , .mstatus_o    (mstatus)
     , .mie_o        (mie)
     , .mip_o        (mip)
     , .mtvec_o      (mtvec)
     , .mepc_o       (mepc)
     );

  trap_ctrl #(.BOOT_PC(BOOT_PC)) u_trap
    (.clk_i            (clk_i)
     , .arst_n_i       (arst_n_i)
     , .req_valid_i    (req_valid_i)
     , .req_i          (req_i)
     , .illegal_i      (illegal)
     , .rd_value_i     (rd_value)
     , .mstatus_i      (mstatus)
     , .mie_i          (mie)
     , .mip_i          (mip)
     , .mtvec_i        (mtvec)
     , .mepc_i         (mepc)
     , .take_trap_o    (take_trap)
     , .trap_irq_o     (trap_irq)
     , .trap_cause_o   (trap_cause)
     , .trap_tval_o    (trap_tval)
     , .trap_pc_o      (trap_pc)
     , .do_mret_o      (do_mret)
     , .priv_o         (priv)
     , .irq_pending_o  (irq_pending_o)
     , .commit_valid_o (commit_valid_o)
     , .commit_o       (commit_o)
     );

endmodule

`default_nettype wire

// ==== sim/tb_clk_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen
  #(parameter int PERIOD = 40
    , parameter int RST_CYCLES = 16
    )
  (output logic clk_o
   , output logic arst_n_o
   );

  initial
    begin
      clk_o = 1'b0;
      forever #(PERIOD / 2) clk_o = ~clk_o;
    end

  // Release on a falling edge, away from the sampling edge
  initial
    begin
      arst_n_o = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      arst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// ==== sim/csr_unit_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_unit_tb;

  import csr_pkg::*;

  localparam xlen_t     HART_ID    = 64'd3;
  localparam xlen_t     BOOT_PC    = 64'h0000_0000_8000_0000;
  localparam xlen_t     MTVEC_VAL  = 64'h0000_0000_8000_1001;
  localparam xlen_t     MTVEC_BASE = 64'h0000_0000_8000_1000;
  localparam xlen_t     RET_PC     = 64'h0000_0000_8000_2000;
  localparam csr_addr_t NO_CSR     = 12'h000;
  localparam int        TIMEOUT    = 20;

  // How rdata is judged
  localparam logic [1:0] RD_EXACT = 2'd0;
  localparam logic [1:0] RD_RISE  = 2'd1;
  localparam logic [1:0] RD_SKIP  = 2'd2;

  typedef struct packed {
    csr_req_t   req;
    logic [2:0] irq;
    logic [1:0] mode;
    logic       trap;
    logic       intr;
    logic       eret;
    xlen_t      rdata;
    xlen_t      npc;
    priv_e      priv;
    logic       pend;
  } row_t;

  logic     clk;
  logic     arst_n;
  logic     req_valid;
  csr_req_t req;
  logic     timer_irq;
  logic     soft_irq;
  logic     ext_irq;
  logic     commit_valid;
  commit_t  commit;
  logic     irq_pending;

  row_t       rows[$];
  integer     seed;
  int         cur_row;
  xlen_t      pc_m;
  xlen_t      epc_m;
  xlen_t      ret_m;
  xlen_t      scratch;
  xlen_t      last_cycle;
  priv_e      priv_m;
  logic [2:0] irq_m;
  logic       pend_m;

  tb_clk_gen #(.PERIOD(40), .RST_CYCLES(16)) u_clk_gen
    (.clk_o      (clk)
     , .arst_n_o (arst_n)
     );

  csr_unit #(.BOOT_PC(BOOT_PC), .HART_ID(HART_ID)) dut_i
    (.clk_i            (clk)
     , .arst_n_i       (arst_n)
     , .req_valid_i    (req_valid)
     , .req_i          (req)
     , .timer_irq_i    (timer_irq)
     , .soft_irq_i     (soft_irq)
     , .ext_irq_i      (ext_irq)
     , .commit_valid_o (commit_valid)
     , .commit_o       (commit)
     , .irq_pending_o  (irq_pending)
     );

  task automatic report_fail;
    begin
      $display("TEST FAILED");
      $fatal(1, "simulation stopped at %0t", $time);
    end
  endtask

  task automatic compare(input string name, input xlen_t act, input xlen_t exp);
    begin
      if (act !== exp)
        begin
          $display("CHECK FAILED %s in row %0d: got %h, expected %h", name, cur_row, act, exp);
          report_fail();
        end
    end
  endtask

  function automatic xlen_t rand64();
    logic [31:0] hi;
    logic [31:0] lo;
    begin
      hi = $random(seed);
      lo = $random(seed);
      return {hi, lo};
    end
  endfunction

  // Expected npc and privilege follow the trap and return rules
  task automatic add_row(input csr_op_e op, input csr_addr_t addr, input xlen_t wdata,
                         input exc_flags_t exc, input xlen_t vaddr, input logic trap,
                         input logic intr, input logic [1:0] mode, input xlen_t rdata);
    row_t r;
    begin
      r.req.op    = op;
      r.req.addr  = addr;
      r.req.wdata = wdata;
      r.req.pc    = pc_m;
      r.req.npc   = pc_m + 64'd4;
      r.req.vaddr = vaddr;
      r.req.exc   = exc;
      r.irq       = irq_m;
      r.mode      = mode;
      r.trap      = trap;
      r.intr      = intr;
      r.eret      = !trap && (op == OP_MRET);
      r.rdata     = rdata;
      r.pend      = pend_m;
      if (trap)
        begin
          r.npc = MTVEC_BASE;
          r.priv = PRIV_M;
          epc_m = pc_m;
        end
      else if (r.eret)
        begin
          // MPP is U at every MRET in this sequence
          r.npc = epc_m;
          r.priv = PRIV_U;
        end
      else
        begin
          r.npc = pc_m + 64'd4;
          r.priv = priv_m;
        end
      if (!trap)
        ret_m = ret_m + 64'd1;
      pc_m = r.npc;
      priv_m = r.priv;
      rows.push_back(r);
    end
  endtask

  task automatic csr_row(input csr_op_e op, input csr_addr_t addr, input xlen_t wdata,
                         input logic [1:0] mode, input xlen_t rdata);
    begin
      add_row(op, addr, wdata, '0, '0, 1'b0, 1'b0, mode, rdata);
    end
  endtask

  task automatic build_table;
    xlen_t      r;
    xlen_t      v;
    exc_flags_t exc;
    begin
      pc_m = BOOT_PC;
      epc_m = '0;
      ret_m = '0;
      priv_m = PRIV_M;
      irq_m = '0;
      pend_m = 1'b0;
      // mtvec and mscratch start unknown
      csr_row(OP_CSRRW, CSR_MTVEC, MTVEC_VAL, RD_SKIP, '0);
      r = rand64();
      csr_row(OP_CSRRW, CSR_MSCRATCH, r, RD_SKIP, '0);
      scratch = r;
      r = rand64();
      csr_row(OP_CSRRW, CSR_MSCRATCH, r, RD_EXACT, scratch);
      scratch = r;
      r = rand64();
      csr_row(OP_CSRRS, CSR_MSCRATCH, r, RD_EXACT, scratch);
      scratch = scratch | r;
      r = rand64();
      csr_row(OP_CSRRC, CSR_MSCRATCH, r, RD_EXACT, scratch);
      scratch = scratch & ~r;
      // Immediate forms use only the low 5 bits
      r = rand64();
      csr_row(OP_CSRRWI, CSR_MSCRATCH, r, RD_EXACT, scratch);
      scratch = {59'd0, r[4:0]};
      r = rand64();
      csr_row(OP_CSRRSI, CSR_MSCRATCH, r, RD_EXACT, scratch);
      scratch = scratch | {59'd0, r[4:0]};
      r = rand64();
      csr_row(OP_CSRRCI, CSR_MSCRATCH, r, RD_EXACT, scratch);
      scratch = scratch & ~{59'd0, r[4:0]};
      csr_row(OP_CSRRS, CSR_MSCRATCH, '0, RD_EXACT, scratch);
      csr_row(OP_CSRRS, CSR_MISA, '0, RD_EXACT, MISA_VALUE);
      csr_row(OP_CSRRS, CSR_MARCHID, '0, RD_EXACT, MARCHID_VALUE);
      csr_row(OP_CSRRS, CSR_MIMPID, '0, RD_EXACT, MIMPID_VALUE);
      csr_row(OP_CSRRS, CSR_MHARTID, '0, RD_EXACT, HART_ID);
      exc = '0;
      exc.load_misaligned = 1'b1;
      v = 64'h0000_0000_0001_2345;
      add_row(OP_NONE, NO_CSR, '0, exc, v, 1'b1, 1'b0, RD_EXACT, '0);
      csr_row(OP_CSRRS, CSR_MEPC, '0, RD_EXACT, epc_m);
      csr_row(OP_CSRRS, CSR_MCAUSE, '0, RD_EXACT, 64'd4);
      csr_row(OP_CSRRS, CSR_MTVAL, '0, RD_EXACT, v);
      // Breakpoint outranks both memory causes
      exc = '0;
      exc.breakpoint = 1'b1;
      exc.load_access_fault = 1'b1;
      exc.store_misaligned = 1'b1;
      add_row(OP_NONE, NO_CSR, '0, exc, 64'h0000_0000_0000_abc8, 1'b1, 1'b0, RD_EXACT, '0);
      csr_row(OP_CSRRS, CSR_MCAUSE, '0, RD_EXACT, 64'd3);
      csr_row(OP_CSRRS, CSR_MTVAL, '0, RD_EXACT, '0);
      csr_row(OP_CSRRW, CSR_MEPC, RET_PC, RD_EXACT, epc_m);
      epc_m = RET_PC;
      // Trap from M left MPP at M with both enables clear
      csr_row(OP_CSRRC, CSR_MSTATUS, 64'h1800, RD_EXACT, 64'h1800);
      add_row(OP_MRET, NO_CSR, '0, '0, '0, 1'b0, 1'b0, RD_EXACT, '0);
      add_row(OP_CSRRS, CSR_MSCRATCH, '0, '0, 64'h0000_0000_0000_7ff8, 1'b1, 1'b0,
              RD_EXACT, '0);
      csr_row(OP_CSRRS, CSR_MCAUSE, '0, RD_EXACT, 64'd2);
      csr_row(OP_CSRRS, CSR_MTVAL, '0, RD_EXACT, '0);
      add_row(OP_MRET, NO_CSR, '0, '0, '0, 1'b0, 1'b0, RD_EXACT, '0);
      exc = '0;
      exc.ecall = 1'b1;
      add_row(OP_NONE, NO_CSR, '0, exc, '0, 1'b1, 1'b0, RD_EXACT, '0);
      csr_row(OP_CSRRS, CSR_MCAUSE, '0, RD_EXACT, 64'd8);
      // Timer line up, then open the hart
      irq_m = 3'b010;
      csr_row(OP_CSRRS, CSR_MIE, 64'h80, RD_EXACT, '0);
      pend_m = 1'b1;
      csr_row(OP_CSRRS, CSR_MSTATUS, 64'h8, RD_EXACT, '0);
      pend_m = 1'b0;
      add_row(OP_CSRRS, CSR_MSCRATCH, '0, '0, '0, 1'b1, 1'b1, RD_EXACT, '0);
      csr_row(OP_CSRRS, CSR_MCAUSE, '0, RD_EXACT, 64'h8000_0000_0000_0007);
      irq_m = 3'b110;
      csr_row(OP_CSRRS, CSR_MIE, 64'h800, RD_EXACT, 64'h80);
      pend_m = 1'b1;
      csr_row(OP_CSRRS, CSR_MSTATUS, 64'h8, RD_EXACT, 64'h1880);
      pend_m = 1'b0;
      add_row(OP_CSRRS, CSR_MSCRATCH, '0, '0, '0, 1'b1, 1'b1, RD_EXACT, '0);
      csr_row(OP_CSRRS, CSR_MCAUSE, '0, RD_EXACT, 64'h8000_0000_0000_000b);
      irq_m = '0;
      csr_row(OP_CSRRS, CSR_MCYCLE, '0, RD_RISE, '0);
      csr_row(OP_CSRRS, CSR_MINSTRET, '0, RD_EXACT, ret_m);
      repeat (3) csr_row(OP_CSRRS, CSR_MSCRATCH, '0, RD_EXACT, scratch);
      add_row(OP_NONE, NO_CSR, '0, exc, '0, 1'b1, 1'b0, RD_EXACT, '0);
      csr_row(OP_CSRRS, CSR_MCAUSE, '0, RD_EXACT, 64'd11);
      csr_row(OP_CSRRS, CSR_MINSTRET, '0, RD_EXACT, ret_m);
      csr_row(OP_CSRRS, CSR_MCYCLE, '0, RD_RISE, '0);
    end
  endtask

  task automatic wait_reset;
    int cnt;
    begin
      cnt = 0;
      while (arst_n !== 1'b1)
        begin
          @(negedge clk);
          cnt = cnt + 1;
          if (cnt > 40)
            begin
              $display("Reset was never released");
              report_fail();
            end
        end
    end
  endtask

  task automatic apply_row(input row_t r);
    int cnt;
    begin
      @(negedge clk);
      // No commit without a request
      compare("commit_valid_o", xlen_t'(commit_valid), '0);
      req_valid = 1'b1;
      req = r.req;
      {ext_irq, timer_irq, soft_irq} = r.irq;
      @(negedge clk);
      req_valid = 1'b0;
      cnt = 0;
      while (!commit_valid)
        begin
          @(negedge clk);
          cnt = cnt + 1;
          if (cnt > TIMEOUT)
            begin
              $display("Timed out waiting for a commit in row %0d", cur_row);
              report_fail();
            end
        end
      if (cnt != 0)
        begin
          $display("Commit of row %0d came %0d cycles late", cur_row, cnt);
          report_fail();
        end
      compare("instret", xlen_t'(commit.instret), xlen_t'(!r.trap));
      compare("trap", xlen_t'(commit.trap), xlen_t'(r.trap));
      compare("interrupt", xlen_t'(commit.interrupt), xlen_t'(r.intr));
      compare("eret", xlen_t'(commit.eret), xlen_t'(r.eret));
      compare("npc", commit.npc, r.npc);
      compare("priv_n", xlen_t'(commit.priv_n), xlen_t'(r.priv));
      compare("irq_pending_o", xlen_t'(irq_pending), xlen_t'(r.pend));
      if (r.mode == RD_EXACT)
        compare("rdata", commit.rdata, r.rdata);
      else if (r.mode == RD_RISE)
        begin
          compare("mcycle rising", xlen_t'(commit.rdata > last_cycle), 64'd1);
          last_cycle = commit.rdata;
        end
    end
  endtask

  initial
    begin
      int idx;
      seed = 11;
      req_valid = 1'b0;
      req = '0;
      timer_irq = 1'b0;
      soft_irq = 1'b0;
      ext_irq = 1'b0;
      last_cycle = '0;
      cur_row = 0;
      build_table();
      wait_reset();
      for (idx = 0; idx < rows.size(); idx++)
        begin
          cur_row = idx;
          apply_row(rows[idx]);
        end
      $display("TEST PASSED");
      $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
verilog/csr_pkg.sv
verilog/csr_operand.sv
verilog/csr_regfile.sv
verilog/trap_ctrl.sv
verilog/csr_unit.sv
sim/tb_clk_gen.sv
sim/csr_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module csr_unit_tb -f project.f || exit 1
./obj_dir/Vcsr_unit_tb > sim.log 2>&1
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || exit 1
exit 0
